// File: src/tlu_config.svh
// ####################
// sizing of the TLU controller
// the divisor must match the ratio of system clock to TLU clock
// word and payload widths fix the FIFO word layout
// ####################
`ifndef TLU_CONFIG_SVH
`define TLU_CONFIG_SVH

// system clock cycles per TLU clock period
`define TLU_CLOCK_DIVISOR 12

// TLU clock periods sent when clock_cycles is zero
`define TLU_MAX_PERIODS 32

// fixed sync part of the wait before the latch
`define TLU_SYNC_CYCLES 3

// read-out FIFO word
`define TLU_WORD_WIDTH 32

// trigger number and timestamp
`define TLU_PAYLOAD_WIDTH 31

`endif

// File: src/tlu_pkg.sv
// ####################
// shared types of the TLU controller
// widths come from the config header
// ####################
`include "tlu_config.svh"

package tlu_pkg;

    // marker field fills the word above the payload
    localparam int MARKER_BITS = `TLU_WORD_WIDTH - `TLU_PAYLOAD_WIDTH;

    typedef enum logic [1:0] {
        mode_no_handshake      = 2'd0,
        mode_simple            = 2'd1,
        mode_trigger_handshake = 2'd2,
        mode_data_handshake    = 2'd3
    } tlu_mode_e;

    typedef logic [`TLU_PAYLOAD_WIDTH-1:0] payload_t;

    typedef struct packed {
        tlu_mode_e  mode;
        // zero disables the timeout
        logic [7:0] low_timeout;
        // zero means max periods
        logic [4:0] clock_cycles;
        logic [3:0] data_delay;
        logic       msb_first;
        logic       disable_veto;
        logic       write_timestamp;
    } tlu_cfg_t;

    // levels towards the TLU
    typedef struct packed {
        logic busy;
        logic clock_enable;
        logic assert_veto;
    } tlu_link_t;

    typedef struct packed {
        logic low_timeout;
        logic accept;
    } tlu_error_t;

    // strobes and qualifiers from the FSM to the event buffer
    typedef struct packed {
        logic capture;
        logic word_expected;
        logic latch;
        logic use_trigger_number;
    } buf_ctrl_t;

    typedef union packed {
        struct packed {
            logic [MARKER_BITS-1:0] marker;
            payload_t               trigger_number;
        } trg;
        struct packed {
            logic [MARKER_BITS-1:0] marker;
            payload_t               timestamp;
        } ts;
    } fifo_word_u;

    // number of TLU clock periods for a clock_cycles setting
    function automatic logic [5:0] num_periods(input logic [4:0] clock_cycles);
        if (clock_cycles == '0)
            return 6'(`TLU_MAX_PERIODS);
        else
            return {1'b0, clock_cycles};
    endfunction

endpackage

// File: src/tlu_trigger_fsm.sv
// ####################
// handshake FSM towards the TLU and the command block
// cfg must stay static while busy is high
// one trigger at a time, a new one is accepted only in idle
// ####################
`timescale 1ns/1ps
`include "tlu_config.svh"

module tlu_trigger_fsm (
    input  logic                CLK,
    input  logic                RESET,
    input  tlu_pkg::tlu_cfg_t   cfg,
    input  logic                cmd_ready,
    input  logic                cmd_ext_start_enable,
    input  logic                tlu_trigger,
    input  logic                tlu_trigger_flag,
    input  logic                ext_veto,
    input  logic                fifo_near_full,
    input  logic                fifo_empty,
    output logic                cmd_ext_start_flag,
    output tlu_pkg::tlu_link_t  tlu_link,
    output tlu_pkg::tlu_error_t errors,
    output tlu_pkg::buf_ctrl_t  buf_ctrl
);
    import tlu_pkg::*;

    localparam int CLK_CNT_W  = $clog2(`TLU_MAX_PERIODS * `TLU_CLOCK_DIVISOR + 1);
    // data_delay is 4 bits wide
    localparam int WAIT_CNT_W = $clog2(2**4 + `TLU_SYNC_CYCLES);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_clock,
        st_wait,
        st_latch,
        st_done
    } state_e;

    state_e                state;
    state_e                next_state;
    logic [7:0]            low_cnt;
    logic [CLK_CNT_W-1:0]  clock_cnt;
    logic [CLK_CNT_W-1:0]  clock_target;
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic [WAIT_CNT_W-1:0] wait_target;
    logic                  cmd_was_busy;
    logic                  handshake_mode;
    logic                  accept;
    logic                  start_done;
    logic                  near_full_veto;
    logic                  timeout_hit;

    assign handshake_mode = (cfg.mode == mode_trigger_handshake)
                            || (cfg.mode == mode_data_handshake);

    // trigger level only counts in the handshake modes
    assign accept = cmd_ready && cmd_ext_start_enable && !ext_veto
                    && (tlu_trigger_flag || (tlu_trigger && handshake_mode));

    assign start_done = !handshake_mode || !tlu_trigger || errors.low_timeout;
    assign near_full_veto = fifo_near_full && !cfg.disable_veto;
    assign timeout_hit = (state == st_start) && (cfg.low_timeout != '0)
                         && (low_cnt >= cfg.low_timeout);

    assign clock_target = CLK_CNT_W'(num_periods(cfg.clock_cycles))
                          * CLK_CNT_W'(`TLU_CLOCK_DIVISOR);
    assign wait_target = WAIT_CNT_W'(cfg.data_delay) + WAIT_CNT_W'(`TLU_SYNC_CYCLES);

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
                if (accept)
                    next_state = st_start;
            st_start:
                if (start_done)
                begin
                    if (cfg.mode == mode_data_handshake)
                        next_state = st_clock;
                    else if (cfg.write_timestamp)
                        next_state = st_latch;
                    else
                        next_state = st_done;
                end
            st_clock:
                if (clock_cnt == clock_target)
                    next_state = st_wait;
            st_wait:
                if (wait_cnt == wait_target)
                    next_state = st_latch;
            st_latch:
                next_state = st_done;
            st_done:
                // word taken and command block has run once
                if (fifo_empty && cmd_ready && cmd_was_busy)
                    next_state = st_idle;
            default:
                next_state = st_idle;
        endcase
    end

    // outputs follow the state being entered
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= st_idle;
            cmd_ext_start_flag <= 1'b0;
            tlu_link <= '0;
            errors <= '0;
            buf_ctrl <= '0;
            low_cnt <= '0;
            clock_cnt <= '0;
            wait_cnt <= '0;
            cmd_was_busy <= 1'b0;
        end
        else
        begin
            state <= next_state;
            cmd_ext_start_flag <= (state == st_idle) && (next_state == st_start);

            tlu_link.busy <= (next_state != st_idle);
            tlu_link.clock_enable <= (next_state == st_clock);
            case (next_state)
                st_idle:
                    tlu_link.assert_veto <= !cmd_ext_start_enable || near_full_veto;
                st_latch, st_done:
                    tlu_link.assert_veto <= near_full_veto;
                default:
                    tlu_link.assert_veto <= 1'b0;
            endcase

            // saturating, so a stuck trigger line cannot wrap it
            if (next_state != st_start)
                low_cnt <= '0;
            else if (low_cnt != '1)
                low_cnt <= low_cnt + 8'd1;

            clock_cnt <= (next_state == st_clock) ? clock_cnt + 1'b1 : '0;
            wait_cnt <= (next_state == st_wait) ? wait_cnt + 1'b1 : '0;

            if (next_state == st_idle)
            begin
                errors.low_timeout <= 1'b0;
                errors.accept <= tlu_trigger && cmd_ext_start_enable;
            end
            else if (timeout_hit)
                errors.low_timeout <= 1'b1;

            if (next_state == st_idle)
                cmd_was_busy <= 1'b0;
            else if (!cmd_ready)
                cmd_was_busy <= 1'b1;

            buf_ctrl.capture <= (state == st_idle) && (next_state == st_start);
            if (next_state == st_idle)
                buf_ctrl.word_expected <= 1'b0;
            else if (state == st_idle)
                buf_ctrl.word_expected <= (cfg.mode == mode_data_handshake)
                                          || cfg.write_timestamp;
            buf_ctrl.latch <= (next_state == st_latch);
            // wait is only reached through the clock state
            buf_ctrl.use_trigger_number <= (state == st_wait) && (next_state == st_latch);
        end
    end

    // the TLU clock only runs inside a data handshake
    a_clock_needs_busy: assert property (
        @(posedge CLK) disable iff (RESET)
        tlu_link.clock_enable |-> tlu_link.busy && (cfg.mode == mode_data_handshake)
    );

    // no second start, and cfg holds once a trigger is in flight
    a_start_flag_single: assert property (
        @(posedge CLK) disable iff (RESET)
        cmd_ext_start_flag |=> !cmd_ext_start_flag && $stable(cfg)
    );

endmodule

// File: src/tlu_serial_receiver.sv
// ####################
// oversampled serial input for the TLU trigger number
// holds max periods times divisor samples, no reset
// number is valid only at the latch strobe
// ####################
`timescale 1ns/1ps
`include "tlu_config.svh"

module tlu_serial_receiver (
    input  logic              CLK,
    input  logic              tlu_trigger,
    input  logic [4:0]        clock_cycles,
    input  logic              msb_first,
    output tlu_pkg::payload_t trigger_number
);
    import tlu_pkg::*;

    localparam int DIVISOR  = `TLU_CLOCK_DIVISOR;
    localparam int SR_DEPTH = `TLU_MAX_PERIODS * `TLU_CLOCK_DIVISOR;

    logic [SR_DEPTH-1:0] sample_sr;
    logic [5:0]          n_periods;

    assign n_periods = num_periods(clock_cycles);

    always_ff @(posedge CLK)
    begin
        sample_sr <= {sample_sr[SR_DEPTH-2:0], tlu_trigger};
    end

    // at the latch the last cycle of period j sits at depth (N-1-j)*divisor
    // period 0 is the TLU latch period and carries no data
    always_comb
    begin
        int period;
        period = 0;
        trigger_number = '0;
        for (int b = 0; b < `TLU_PAYLOAD_WIDTH; b++)
        begin
            if (b < int'(n_periods) - 1)
            begin
                if (msb_first)
                    period = int'(n_periods) - 1 - b;
                else
                    period = b + 1;
                trigger_number[b] = sample_sr[(int'(n_periods) - 1 - period) * DIVISOR];
            end
        end
    end

endmodule

// File: src/tlu_event_buffer.sv
// ####################
// timestamp counter and single-word output to the read-out FIFO
// holds one word only, the FSM waits in done until it is read
// ####################
`timescale 1ns/1ps

module tlu_event_buffer (
    input  logic                CLK,
    input  logic                RESET,
    input  tlu_pkg::buf_ctrl_t  buf_ctrl,
    input  tlu_pkg::payload_t   trigger_number,
    input  logic                fifo_read,
    output logic                fifo_empty,
    output logic                fifo_preempt_req,
    output logic                tlu_data_ready_flag,
    output tlu_pkg::fifo_word_u fifo_data,
    output tlu_pkg::payload_t   tlu_data
);
    import tlu_pkg::*;

    payload_t timestamp;
    payload_t timestamp_capt;

    // cycles since reset
    always_ff @(posedge CLK)
    begin
        if (RESET)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (buf_ctrl.capture)
            timestamp_capt <= timestamp;

        if (buf_ctrl.latch)
        begin
            if (buf_ctrl.use_trigger_number)
            begin
                fifo_data.trg.marker <= '1;
                fifo_data.trg.trigger_number <= trigger_number;
                tlu_data <= trigger_number;
            end
            else
            begin
                fifo_data.ts.marker <= '1;
                fifo_data.ts.timestamp <= timestamp_capt;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            fifo_empty <= 1'b1;
            fifo_preempt_req <= 1'b0;
            tlu_data_ready_flag <= 1'b0;
        end
        else
        begin
            tlu_data_ready_flag <= buf_ctrl.latch;

            if (buf_ctrl.latch)
                fifo_empty <= 1'b0;
            else if (fifo_read)
                fifo_empty <= 1'b1;

            // ask the FIFO arbiter early, a word is on its way
            if (fifo_read)
                fifo_preempt_req <= 1'b0;
            else if (buf_ctrl.capture && buf_ctrl.word_expected)
                fifo_preempt_req <= 1'b1;
        end
    end

    a_no_overwrite: assert property (
        @(posedge CLK) disable iff (RESET)
        buf_ctrl.latch |-> fifo_empty
    );

endmodule

// File: src/tlu_controller.sv
// ####################
// TLU trigger controller top
// cfg is sampled every cycle and must be static while busy
// ####################
`timescale 1ns/1ps

module tlu_controller (
    input  logic                CLK,
    input  logic                RESET,
    input  tlu_pkg::tlu_cfg_t   cfg,
    input  logic                cmd_ready,
    input  logic                cmd_ext_start_enable,
    input  logic                tlu_trigger,
    input  logic                tlu_trigger_flag,
    input  logic                ext_veto,
    input  logic                fifo_near_full,
    input  logic                fifo_read,
    output logic                cmd_ext_start_flag,
    output tlu_pkg::tlu_link_t  tlu_link,
    output tlu_pkg::tlu_error_t errors,
    output logic                fifo_empty,
    output logic                fifo_preempt_req,
    output logic                tlu_data_ready_flag,
    output tlu_pkg::fifo_word_u fifo_data,
    output tlu_pkg::payload_t   tlu_data
);
    import tlu_pkg::*;

    buf_ctrl_t buf_ctrl;
    payload_t  trigger_number;

    tlu_trigger_fsm u_fsm (
        .CLK                  (CLK),
        .RESET                (RESET),
        .cfg                  (cfg),
        .cmd_ready            (cmd_ready),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .tlu_trigger          (tlu_trigger),
        .tlu_trigger_flag     (tlu_trigger_flag),
        .ext_veto             (ext_veto),
        .fifo_near_full       (fifo_near_full),
        .fifo_empty           (fifo_empty),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .tlu_link             (tlu_link),
        .errors               (errors),
        .buf_ctrl             (buf_ctrl)
    );

    // serial line doubles as the trigger level
    tlu_serial_receiver u_rx (
        .CLK            (CLK),
        .tlu_trigger    (tlu_trigger),
        .clock_cycles   (cfg.clock_cycles),
        .msb_first      (cfg.msb_first),
        .trigger_number (trigger_number)
    );

    tlu_event_buffer u_buf (
        .CLK                 (CLK),
        .RESET               (RESET),
        .buf_ctrl            (buf_ctrl),
        .trigger_number      (trigger_number),
        .fifo_read           (fifo_read),
        .fifo_empty          (fifo_empty),
        .fifo_preempt_req    (fifo_preempt_req),
        .tlu_data_ready_flag (tlu_data_ready_flag),
        .fifo_data           (fifo_data),
        .tlu_data            (tlu_data)
    );

endmodule

// File: testbench/tb_tlu_controller.sv
// ####################
// testbench for the TLU trigger controller
// models the command block, the TLU and a FIFO reader
// ####################
`timescale 1ns/1ps
`include "tlu_config.svh"

module tb_tlu_controller;
    import tlu_pkg::*;

    localparam int DIV = `TLU_CLOCK_DIVISOR;
    localparam int MAX_CYCLES = 40000;

    logic CLK = 1'b0;
    logic RESET, cmd_ready, cmd_ext_start_enable, tlu_trigger_flag, ext_veto;
    logic fifo_near_full, fifo_read, tlu_serial, trigger_level, tlu_trigger;
    logic cmd_ext_start_flag, fifo_empty, fifo_preempt_req, tlu_data_ready_flag;
    tlu_cfg_t   cfg;
    tlu_link_t  tlu_link;
    tlu_error_t errors;
    fifo_word_u fifo_data;
    payload_t   tlu_data;
    payload_t   last_ts;
    payload_t   exp_number;
    logic [31:0] tlu_word;
    int error_count = 0;
    int cycles = 0;
    int start_flags = 0;
    int words = 0;
    int ce_len = 0;
    int ce_rises = 0;
    int prev_flags, prev_words;
    logic busy_prev = 1'b0;

    // serial line also carries the trigger level
    assign tlu_trigger = tlu_serial || trigger_level;

    tlu_controller u_dut (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %0t: %s got %h expected %h", $time, msg, got, exp);
            error_count++;
        end
    endtask

    // bit order of the serial trigger number as sent by the TLU
    function automatic logic [30:0] expected_trigger_number(input logic [31:0] seq,
                                                            input int n, input logic msb);
        logic [30:0] r;
        r = '0;
        for (int b = 0; b < 31; b++)
        begin
            if (b < n - 1)
                r[b] = msb ? seq[n - 1 - b] : seq[b + 1];
        end
        return r;
    endfunction

    function automatic int periods_of(input logic [4:0] cc);
        return (cc == 5'd0) ? 32 : int'(cc);
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic wait_drive_time();
        @(posedge CLK);
        #1;
    endtask

    // command block: busy for a few cycles after each start
    initial
    begin
        forever
        begin
            @(negedge CLK);
            if (cmd_ext_start_flag)
            begin
                @(posedge CLK);
                #1 cmd_ready = 1'b0;
                repeat ($urandom_range(6, 2)) @(posedge CLK);
                #1 cmd_ready = 1'b1;
            end
        end
    end

    // TLU: bit j in period j, shifted by the data delay
    initial
    begin
        int w;
        int total;
        forever
        begin
            @(posedge CLK);
            #1;
            if (tlu_link.clock_enable)
            begin
                w = int'(cfg.data_delay) + 3;
                total = periods_of(cfg.clock_cycles) * DIV;
                for (int c = 0; c < total + w; c++)
                begin
                    tlu_serial = (c >= w) ? tlu_word[(c - w) / DIV] : 1'b0;
                    @(posedge CLK);
                    #1;
                end
                tlu_serial = 1'b0;
            end
        end
    end

    // FIFO reader with random latency
    initial
    begin
        forever
        begin
            @(negedge CLK);
            if (!fifo_empty)
            begin
                check_value("preempt before read", 32'(fifo_preempt_req), 32'd1);
                repeat ($urandom_range(8, 0)) @(posedge CLK);
                @(posedge CLK);
                #1 fifo_read = 1'b1;
                @(posedge CLK);
                #1 fifo_read = 1'b0;
                check_value("preempt after read", 32'(fifo_preempt_req), 32'd0);
                check_value("empty after read", 32'(fifo_empty), 32'd1);
            end
        end
    end

    // compare process, sampled mid-cycle
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            if (cmd_ext_start_flag)
                start_flags++;
            if (tlu_link.clock_enable)
                ce_len++;
            else if (ce_len != 0)
            begin
                check_value("clock_enable length", 32'(ce_len),
                            32'(periods_of(cfg.clock_cycles) * DIV));
                ce_len = 0;
                ce_rises++;
            end
            if (busy_prev && !tlu_link.busy)
                check_value("command done at busy fall", 32'(cmd_ready), 32'd1);
            busy_prev = tlu_link.busy;
            if (tlu_data_ready_flag)
            begin
                words++;
                check_value("marker", 32'(fifo_data.trg.marker), 32'd1);
                if (cfg.mode == mode_data_handshake)
                begin
                    exp_number = expected_trigger_number(tlu_word,
                                     periods_of(cfg.clock_cycles), cfg.msb_first);
                    check_value("trigger number", 32'(fifo_data.trg.trigger_number),
                                32'(exp_number));
                    check_value("tlu_data", 32'(tlu_data), 32'(exp_number));
                end
                else
                begin
                    check_value("timestamp increases",
                                32'(fifo_data.ts.timestamp > last_ts), 32'd1);
                    last_ts = fifo_data.ts.timestamp;
                end
            end
        end
    end

    task automatic pulse_trigger_flag();
        @(posedge CLK);
        #1 tlu_trigger_flag = 1'b1;
        @(posedge CLK);
        #1 tlu_trigger_flag = 1'b0;
    endtask

    task automatic wait_idle();
        do
            @(negedge CLK);
        while (tlu_link.busy || !cmd_ready || !fifo_empty || fifo_read);
        wait_drive_time();
    endtask

    initial
    begin
        void'($urandom(81));
        RESET = 1'b1;
        cfg = '0;
        cmd_ready = 1'b1;
        cmd_ext_start_enable = 1'b1;
        tlu_trigger_flag = 1'b0;
        ext_veto = 1'b0;
        fifo_near_full = 1'b0;
        fifo_read = 1'b0;
        tlu_serial = 1'b0;
        trigger_level = 1'b0;
        tlu_word = '0;
        last_ts = '0;
        exp_number = '0;
        repeat (10) @(posedge CLK);
        #1 RESET = 1'b0;
        @(negedge CLK);
        check_value("link after reset", 32'(tlu_link), 32'd0);
        check_value("errors after reset", 32'(errors), 32'd0);
        check_value("flags after reset",
                    32'({cmd_ext_start_flag, fifo_preempt_req, tlu_data_ready_flag}), 32'd0);
        check_value("fifo_empty after reset", 32'(fifo_empty), 32'd1);
        wait_drive_time();

        // modes 0 and 1, no word and no TLU clock
        for (int i = 0; i < 10; i++)
        begin
            cfg.mode = (i < 5) ? mode_no_handshake : mode_simple;
            prev_flags = start_flags;
            pulse_trigger_flag();
            wait_idle();
            check_value("one start per flag", 32'(start_flags - prev_flags), 32'd1);
        end
        check_value("no words without handshake", 32'(words), 32'd0);
        check_value("no TLU clock without handshake", 32'(ce_rises), 32'd0);

        // data handshake with random numbers
        cfg.mode = mode_data_handshake;
        for (int i = 0; i < 15; i++)
        begin
            cfg.clock_cycles = 5'($urandom);
            cfg.msb_first = 1'($urandom);
            cfg.data_delay = 4'($urandom);
            tlu_word = $urandom;
            prev_words = words;
            pulse_trigger_flag();
            wait_idle();
            check_value("one word per trigger", 32'(words - prev_words), 32'd1);
        end
        check_value("TLU clock bursts", 32'(ce_rises), 32'd15);

        // trigger handshake with timestamps
        cfg.mode = mode_trigger_handshake;
        cfg.write_timestamp = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            prev_words = words;
            prev_flags = start_flags;
            @(posedge CLK);
            #1 trigger_level = 1'b1;
            while (start_flags == prev_flags)
                @(negedge CLK);
            repeat (6) @(negedge CLK);
            check_value("no word while trigger high", 32'(words - prev_words), 32'd0);
            @(posedge CLK);
            #1 trigger_level = 1'b0;
            wait_idle();
            check_value("timestamp word", 32'(words - prev_words), 32'd1);
        end

        // trigger stuck high runs into the timeout
        cfg.write_timestamp = 1'b0;
        cfg.low_timeout = 8'd20;
        prev_flags = start_flags;
        @(posedge CLK);
        #1 trigger_level = 1'b1;
        while (!errors.low_timeout)
            @(negedge CLK);
        @(posedge CLK);
        #1 trigger_level = 1'b0;
        wait_idle();
        check_value("timeout start count", 32'(start_flags - prev_flags), 32'd1);
        check_value("timeout cleared in idle", 32'(errors.low_timeout), 32'd0);

        // veto rules in idle
        cfg.low_timeout = 8'd0;
        cfg.mode = mode_simple;
        fifo_near_full = 1'b1;
        repeat (2) @(negedge CLK);
        check_value("veto on near full", 32'(tlu_link.assert_veto), 32'd1);
        wait_drive_time();
        cfg.disable_veto = 1'b1;
        repeat (2) @(negedge CLK);
        check_value("veto disabled", 32'(tlu_link.assert_veto), 32'd0);
        wait_drive_time();
        fifo_near_full = 1'b0;
        ext_veto = 1'b1;
        prev_flags = start_flags;
        pulse_trigger_flag();
        repeat (10) @(negedge CLK);
        check_value("ext_veto blocks start", 32'(start_flags - prev_flags), 32'd0);
        wait_drive_time();
        ext_veto = 1'b0;

        $display("checks done, errors: %0d", error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/tlu_pkg.sv
src/tlu_trigger_fsm.sv
src/tlu_serial_receiver.sv
src/tlu_event_buffer.sv
src/tlu_controller.sv
testbench/tb_tlu_controller.sv

// File: run_sim.sh
#!/bin/sh
# build and run the TLU controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_tlu_controller -o sim_tlu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tlu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
else
    exit 1
fi
